/* design/beat_packer.sv */
`timescale 1ns/1ps

module beat_packer (
   input  logic                      M_AXIS_ACLK,
   input  logic                      reset_n,

   input  dma_rx_pkg::in_data_t      s_axis_tdata,
   input  dma_rx_pkg::in_strb_t      s_axis_tstrb,
   input  dma_rx_pkg::user_t         s_axis_tuser,
   input  logic                      s_axis_tlast,
   input  logic                      s_axis_tvalid,
   output logic                      s_axis_tready,

   output dma_rx_pkg::out_data_t     m_axis_tdata,
   output dma_rx_pkg::out_strb_t     m_axis_tstrb,
   output dma_rx_pkg::user_t         m_axis_tuser,
   output logic                      m_axis_tlast,
   output logic                      m_axis_tvalid,
   input  logic                      m_axis_tready,

   output dma_rx_pkg::packer_state_t packer_state
);

   // Assembly register
   dma_rx_pkg::out_data_t         asm_data;
   dma_rx_pkg::out_strb_t         asm_strb;
   dma_rx_pkg::user_t             asm_user;    // tuser of the packet's first beat
   logic [dma_rx_pkg::LANE_W-1:0] asm_lane;    // Lane the next beat lands in

   dma_rx_pkg::out_data_t     next_data;
   dma_rx_pkg::out_strb_t     next_strb;
   dma_rx_pkg::user_t         pkt_user;
   dma_rx_pkg::packer_state_t state_next;
   logic                      beat_acc;
   logic                      word_done;

   // Accept while the output register is empty or draining this cycle
   assign s_axis_tready = !m_axis_tvalid || m_axis_tready;
   assign beat_acc      = s_axis_tvalid && s_axis_tready;
   assign word_done     = (asm_lane == dma_rx_pkg::LANE_W'(dma_rx_pkg::LANES - 1))
                          || s_axis_tlast;

   assign pkt_user = (packer_state == dma_rx_pkg::PK_IDLE) ? s_axis_tuser : asm_user;

   // Merge the incoming beat; lanes above it stay zero
   always_comb begin
      next_data = '0;
      next_strb = '0;
      for (int i = 0; i < dma_rx_pkg::LANES; i++) begin
         if (i < int'(asm_lane)) begin
            next_data[i*dma_rx_pkg::IN_DATA_W +: dma_rx_pkg::IN_DATA_W] =
               asm_data[i*dma_rx_pkg::IN_DATA_W +: dma_rx_pkg::IN_DATA_W];
            next_strb[i*dma_rx_pkg::IN_STRB_W +: dma_rx_pkg::IN_STRB_W] =
               asm_strb[i*dma_rx_pkg::IN_STRB_W +: dma_rx_pkg::IN_STRB_W];
         end else if (i == int'(asm_lane)) begin
            next_data[i*dma_rx_pkg::IN_DATA_W +: dma_rx_pkg::IN_DATA_W] = s_axis_tdata;
            next_strb[i*dma_rx_pkg::IN_STRB_W +: dma_rx_pkg::IN_STRB_W] = s_axis_tstrb;
         end
      end
   end

   // Packet start tracking
   always_comb begin
      state_next = packer_state;
      case (packer_state)
         dma_rx_pkg::PK_IDLE: begin
            if (beat_acc && !s_axis_tlast) state_next = dma_rx_pkg::PK_FILL;
         end
         dma_rx_pkg::PK_FILL: begin
            if (beat_acc && s_axis_tlast) state_next = dma_rx_pkg::PK_IDLE;
         end
         default: state_next = dma_rx_pkg::PK_IDLE;
      endcase
   end

   always_ff @(posedge M_AXIS_ACLK) begin
      if (!reset_n) begin
         packer_state  <= dma_rx_pkg::PK_IDLE;
         asm_lane      <= '0;
         m_axis_tvalid <= 1'b0;
      end else begin
         packer_state <= state_next;
         if (m_axis_tvalid && m_axis_tready) m_axis_tvalid <= 1'b0;   // Drained
         if (beat_acc) begin
            if (word_done) begin
               asm_lane      <= '0;
               m_axis_tvalid <= 1'b1;   // Wins over the drain above
            end else begin
               asm_lane <= asm_lane + 1'b1;
            end
         end
      end
   end

   // Payload
   always_ff @(posedge M_AXIS_ACLK) begin
      if (beat_acc) begin
         asm_data <= next_data;
         asm_strb <= next_strb;
         asm_user <= pkt_user;
         if (word_done) begin
            m_axis_tdata <= next_data;
            m_axis_tstrb <= next_strb;
            m_axis_tuser <= pkt_user;
            m_axis_tlast <= s_axis_tlast;
         end
      end
   end

endmodule

/* design/dma_rx_path.sv */
`timescale 1ns/1ps

module dma_rx_path (
   input  logic                    M_AXIS_ACLK,
   input  logic                    reset_n,

   // 64-bit stream from the DMA side
   input  dma_rx_pkg::in_data_t    s_axis_tdata,
   input  dma_rx_pkg::in_strb_t    s_axis_tstrb,
   input  dma_rx_pkg::user_t       s_axis_tuser,
   input  logic                    s_axis_tlast,
   input  logic                    s_axis_tvalid,
   output logic                    s_axis_tready,

   // 256-bit user stream
   output dma_rx_pkg::out_data_t   m_axis_tdata,
   output dma_rx_pkg::out_strb_t   m_axis_tstrb,
   output dma_rx_pkg::user_t       m_axis_tuser,
   output logic                    m_axis_tlast,
   output logic                    m_axis_tvalid,
   input  logic                    m_axis_tready,

   // Wishbone register slave
   input  logic                    wb_cyc,
   input  logic                    wb_stb,
   input  logic                    wb_we,
   input  dma_rx_pkg::wb_adr_t     wb_adr,
   input  dma_rx_pkg::wb_dat_t     wb_dat_w,
   output logic                    wb_ack,
   output dma_rx_pkg::wb_dat_t     wb_dat_r
);

   dma_rx_pkg::packer_state_t packer_state;
   dma_rx_pkg::cnt_t          pkt_out;
   dma_rx_pkg::cnt_t          word_out;
   dma_rx_pkg::cnt_t          pkt_in;
   dma_rx_pkg::cnt_t          word_in;
   dma_rx_pkg::cnt_t          err_in;
   dma_rx_pkg::cnt_t          extra_in;
   logic                      clear;      // Counter clear from the register slave

   beat_packer packer0 (
      .M_AXIS_ACLK   (M_AXIS_ACLK),
      .reset_n       (reset_n),
      .s_axis_tdata  (s_axis_tdata),
      .s_axis_tstrb  (s_axis_tstrb),
      .s_axis_tuser  (s_axis_tuser),
      .s_axis_tlast  (s_axis_tlast),
      .s_axis_tvalid (s_axis_tvalid),
      .s_axis_tready (s_axis_tready),
      .m_axis_tdata  (m_axis_tdata),
      .m_axis_tstrb  (m_axis_tstrb),
      .m_axis_tuser  (m_axis_tuser),
      .m_axis_tlast  (m_axis_tlast),
      .m_axis_tvalid (m_axis_tvalid),
      .m_axis_tready (m_axis_tready),
      .packer_state  (packer_state)
   );

   // Watches both sides of the packer
   traffic_counters counters0 (
      .M_AXIS_ACLK   (M_AXIS_ACLK),
      .reset_n       (reset_n),
      .clear         (clear),
      .s_axis_tdata  (s_axis_tdata),
      .s_axis_tstrb  (s_axis_tstrb),
      .s_axis_tlast  (s_axis_tlast),
      .s_axis_tvalid (s_axis_tvalid),
      .s_axis_tready (s_axis_tready),
      .m_axis_tlast  (m_axis_tlast),
      .m_axis_tvalid (m_axis_tvalid),
      .m_axis_tready (m_axis_tready),
      .pkt_out       (pkt_out),
      .word_out      (word_out),
      .pkt_in        (pkt_in),
      .word_in       (word_in),
      .err_in        (err_in),
      .extra_in      (extra_in)
   );

   wb_stat_regs regs0 (
      .M_AXIS_ACLK  (M_AXIS_ACLK),
      .reset_n      (reset_n),
      .wb_cyc       (wb_cyc),
      .wb_stb       (wb_stb),
      .wb_we        (wb_we),
      .wb_adr       (wb_adr),
      .wb_dat_w     (wb_dat_w),
      .wb_ack       (wb_ack),
      .wb_dat_r     (wb_dat_r),
      .pkt_out      (pkt_out),
      .word_out     (word_out),
      .pkt_in       (pkt_in),
      .word_in      (word_in),
      .err_in       (err_in),
      .extra_in     (extra_in),
      .packer_state (packer_state),
      .clear        (clear)
   );

endmodule

/* design/dma_rx_pkg.sv */
package dma_rx_pkg;

   // Stream widths
   localparam int IN_DATA_W  = 64;
   localparam int OUT_DATA_W = 256;
   localparam int IN_STRB_W  = IN_DATA_W / 8;
   localparam int OUT_STRB_W = OUT_DATA_W / 8;
   localparam int LANES      = OUT_DATA_W / IN_DATA_W;  // 64-bit lanes per egress beat
   localparam int LANE_W     = $clog2(LANES);           // Lane index width
   localparam int USER_W     = 128;

   // Statistics and register bus
   localparam int CNT_W    = 32;
   localparam int WB_ADR_W = 5;   // Byte address over eight words
   localparam int WB_DAT_W = 32;

   typedef logic [IN_DATA_W-1:0]  in_data_t;
   typedef logic [OUT_DATA_W-1:0] out_data_t;
   typedef logic [IN_STRB_W-1:0]  in_strb_t;
   typedef logic [OUT_STRB_W-1:0] out_strb_t;
   typedef logic [USER_W-1:0]     user_t;
   typedef logic [CNT_W-1:0]      cnt_t;
   typedef logic [WB_ADR_W-1:0]   wb_adr_t;
   typedef logic [WB_DAT_W-1:0]   wb_dat_t;

   typedef enum logic [1:0] {
      PK_IDLE = 2'd0,   // Next accepted beat opens a packet
      PK_FILL = 2'd1    // Packet open
   } packer_state_t;

   typedef enum logic [2:0] {
      REG_PKT_OUT      = 3'd0,
      REG_WORD_OUT     = 3'd1,
      REG_PKT_IN       = 3'd2,
      REG_WORD_IN      = 3'd3,
      REG_ERR_IN       = 3'd4,
      REG_EXTRA_IN     = 3'd5,
      REG_PACKER_STATE = 3'd6,
      REG_CLEAR        = 3'd7
   } reg_index_t;

endpackage

/* design/traffic_counters.sv */
`timescale 1ns/1ps

module traffic_counters (
   input  logic                 M_AXIS_ACLK,
   input  logic                 reset_n,
   input  logic                 clear,

   // Ingress handshake
   input  dma_rx_pkg::in_data_t s_axis_tdata,
   input  dma_rx_pkg::in_strb_t s_axis_tstrb,
   input  logic                 s_axis_tlast,
   input  logic                 s_axis_tvalid,
   input  logic                 s_axis_tready,

   // Egress handshake
   input  logic                 m_axis_tlast,
   input  logic                 m_axis_tvalid,
   input  logic                 m_axis_tready,

   output dma_rx_pkg::cnt_t     pkt_out,
   output dma_rx_pkg::cnt_t     word_out,
   output dma_rx_pkg::cnt_t     pkt_in,
   output dma_rx_pkg::cnt_t     word_in,
   output dma_rx_pkg::cnt_t     err_in,
   output dma_rx_pkg::cnt_t     extra_in
);

   logic in_xfer;
   logic out_xfer;

   assign in_xfer  = s_axis_tvalid && s_axis_tready;
   assign out_xfer = m_axis_tvalid && m_axis_tready;

   always_ff @(posedge M_AXIS_ACLK) begin
      if (!reset_n || clear) begin   // Clear drops any transfer at this edge
         pkt_out  <= '0;
         word_out <= '0;
         pkt_in   <= '0;
         word_in  <= '0;
         err_in   <= '0;
         extra_in <= '0;
      end else begin
         if (out_xfer) begin
            word_out <= word_out + 1'b1;
            if (m_axis_tlast) pkt_out <= pkt_out + 1'b1;
         end

         if (in_xfer) begin
            if (s_axis_tlast) pkt_in <= pkt_in + 1'b1;

            // A full beat or the packet tail counts as one word
            if (s_axis_tlast || (&s_axis_tstrb)) word_in <= word_in + 1'b1;

            if (s_axis_tdata == '0) err_in <= err_in + 1'b1;   // All-zero beat

            // Beats seen since the last packet end
            if (s_axis_tlast) begin
               extra_in <= '0;
            end else begin
               extra_in <= extra_in + 1'b1;
            end
         end
      end
   end

endmodule

/* design/wb_stat_regs.sv */
`timescale 1ns/1ps

module wb_stat_regs (
   input  logic                      M_AXIS_ACLK,
   input  logic                      reset_n,

   // Wishbone classic slave
   input  logic                      wb_cyc,
   input  logic                      wb_stb,
   input  logic                      wb_we,
   input  dma_rx_pkg::wb_adr_t       wb_adr,
   input  dma_rx_pkg::wb_dat_t       wb_dat_w,   // Any write clears whatever the value
   output logic                      wb_ack,
   output dma_rx_pkg::wb_dat_t       wb_dat_r,

   // Statistics and packer status
   input  dma_rx_pkg::cnt_t          pkt_out,
   input  dma_rx_pkg::cnt_t          word_out,
   input  dma_rx_pkg::cnt_t          pkt_in,
   input  dma_rx_pkg::cnt_t          word_in,
   input  dma_rx_pkg::cnt_t          err_in,
   input  dma_rx_pkg::cnt_t          extra_in,
   input  dma_rx_pkg::packer_state_t packer_state,

   output logic                      clear
);

   dma_rx_pkg::reg_index_t reg_idx;
   dma_rx_pkg::wb_dat_t    rd_val;
   logic                   req;

   // Ignore the request already being acked
   assign req = wb_cyc && wb_stb && !wb_ack;

   // Byte address to word index
   assign reg_idx = dma_rx_pkg::reg_index_t'(wb_adr[dma_rx_pkg::WB_ADR_W-1:2]);

   // Counters zero at the edge that raises the ack
   assign clear = req && wb_we && (reg_idx == dma_rx_pkg::REG_CLEAR);

   always_comb begin
      case (reg_idx)
         dma_rx_pkg::REG_PKT_OUT:      rd_val = pkt_out;
         dma_rx_pkg::REG_WORD_OUT:     rd_val = word_out;
         dma_rx_pkg::REG_PKT_IN:       rd_val = pkt_in;
         dma_rx_pkg::REG_WORD_IN:      rd_val = word_in;
         dma_rx_pkg::REG_ERR_IN:       rd_val = err_in;
         dma_rx_pkg::REG_EXTRA_IN:     rd_val = extra_in;
         dma_rx_pkg::REG_PACKER_STATE: rd_val = dma_rx_pkg::wb_dat_t'(packer_state);
         dma_rx_pkg::REG_CLEAR:        rd_val = '0;   // Write-only
         default:                      rd_val = '0;
      endcase
   end

   always_ff @(posedge M_AXIS_ACLK) begin
      if (!reset_n) begin
         wb_ack <= 1'b0;
      end else begin
         wb_ack <= req;   // Writes elsewhere acked and dropped
      end
   end

   // Snapshot taken at the request edge
   always_ff @(posedge M_AXIS_ACLK) begin
      if (req) wb_dat_r <= rd_val;
   end

endmodule

/* dma_rx_path.f */
design/dma_rx_pkg.sv
design/beat_packer.sv
design/traffic_counters.sv
design/wb_stat_regs.sv
design/dma_rx_path.sv
dv/dma_rx_path_properties.sv
dv/dma_rx_path_tb.sv

/* dv/dma_rx_path_properties.sv */
`timescale 1ns/1ps

module dma_rx_path_properties (
   input logic                  M_AXIS_ACLK,
   input logic                  reset_n,
   input logic                  s_axis_tready,
   input dma_rx_pkg::out_data_t m_axis_tdata,
   input logic                  m_axis_tvalid,
   input logic                  m_axis_tready,
   input logic                  wb_cyc,
   input logic                  wb_stb,
   input logic                  wb_ack
);

   // Stalled egress word must not move
   egress_hold: assert property (@(posedge M_AXIS_ACLK) disable iff (!reset_n)
      m_axis_tvalid && !m_axis_tready |=> m_axis_tvalid && $stable(m_axis_tdata))
      else $error("Egress word changed while stalled");

   ingress_ready: assert property (@(posedge M_AXIS_ACLK) disable iff (!reset_n)
      !m_axis_tvalid |-> s_axis_tready)
      else $error("s_axis_tready low with an empty output register");

   ack_after_req: assert property (@(posedge M_AXIS_ACLK) disable iff (!reset_n)
      wb_ack |-> $past(wb_cyc && wb_stb))
      else $error("wb_ack raised without a request");

   ack_single: assert property (@(posedge M_AXIS_ACLK) disable iff (!reset_n)
      wb_ack |=> !wb_ack)
      else $error("wb_ack high on two cycles in a row");

endmodule

bind dma_rx_path dma_rx_path_properties props0 (
   .M_AXIS_ACLK   (M_AXIS_ACLK),
   .reset_n       (reset_n),
   .s_axis_tready (s_axis_tready),
   .m_axis_tdata  (m_axis_tdata),
   .m_axis_tvalid (m_axis_tvalid),
   .m_axis_tready (m_axis_tready),
   .wb_cyc        (wb_cyc),
   .wb_stb        (wb_stb),
   .wb_ack        (wb_ack)
);

/* dv/dma_rx_path_tb.sv */
`timescale 1ns/1ps

module dma_rx_path_tb;

   logic                  M_AXIS_ACLK;
   logic                  reset_n;
   dma_rx_pkg::in_data_t  s_axis_tdata;
   dma_rx_pkg::in_strb_t  s_axis_tstrb;
   dma_rx_pkg::user_t     s_axis_tuser;
   logic                  s_axis_tlast;
   logic                  s_axis_tvalid;
   logic                  s_axis_tready;
   dma_rx_pkg::out_data_t m_axis_tdata;
   dma_rx_pkg::out_strb_t m_axis_tstrb;
   dma_rx_pkg::user_t     m_axis_tuser;
   logic                  m_axis_tlast;
   logic                  m_axis_tvalid;
   logic                  m_axis_tready;
   logic                  wb_cyc;
   logic                  wb_stb;
   logic                  wb_we;
   dma_rx_pkg::wb_adr_t   wb_adr;
   dma_rx_pkg::wb_dat_t   wb_dat_w;
   logic                  wb_ack;
   dma_rx_pkg::wb_dat_t   wb_dat_r;

   dma_rx_path dut0 (.*);

   // Pending ingress beat and bus request for the next rising edge
   dma_rx_pkg::in_data_t  beat_data;
   dma_rx_pkg::in_strb_t  beat_strb;
   dma_rx_pkg::user_t     beat_user;
   logic                  beat_last;
   logic                  beat_pending;
   logic                  req_on;
   logic                  req_we;
   dma_rx_pkg::wb_adr_t   req_adr;
   logic                  bp_en;          // Random egress back-pressure

   logic [416:0]          exp_q[$];       // {data, strb, user, last} per egress word
   dma_rx_pkg::out_data_t mdl_data;
   dma_rx_pkg::out_strb_t mdl_strb;
   dma_rx_pkg::user_t     mdl_user;
   int                    mdl_lane;
   logic                  mdl_open;
   dma_rx_pkg::cnt_t      mdl_cnt[6];     // Same order as registers 0 to 5

   logic [31:0]           lfsr = 32'h8c06;
   string                 test_name;
   int                    word_errs;
   int                    count_errs;
   int                    state_errs;
   int                    other_errs;

   initial begin
      M_AXIS_ACLK = 1'b0;
      forever #4 M_AXIS_ACLK = ~M_AXIS_ACLK;
   end

   // Fibonacci LFSR with taps 32 22 2 1
   function automatic logic [31:0] lfsr_step(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   task automatic take_bits(input int n, output logic [63:0] v);
      v = '0;
      for (int i = 0; i < n; i++) begin
         lfsr = lfsr_step(lfsr);
         v    = {v[62:0], lfsr[0]};
      end
   endtask

   task automatic check_word(input string name, input dma_rx_pkg::out_data_t ed,
                             input dma_rx_pkg::out_strb_t es, input dma_rx_pkg::user_t eu,
                             input logic el, input dma_rx_pkg::out_data_t ad,
                             input dma_rx_pkg::out_strb_t as_, input dma_rx_pkg::user_t au,
                             input logic al);
      if (ad !== ed || as_ !== es || au !== eu || al !== el) begin
         word_errs++;
         $write("Mismatch %s: expected data %h strb %h user %h last %b, ",
                name, ed, es, eu, el);
         $display("actual data %h strb %h user %h last %b", ad, as_, au, al);
      end
   endtask

   task automatic check_count(input string name, input dma_rx_pkg::cnt_t exp,
                              input dma_rx_pkg::cnt_t act);
      if (act !== exp) begin
         count_errs++;
         $display("Mismatch %s: expected %0d, actual %0d", name, exp, act);
      end
   endtask

   task automatic check_state(input string name, input dma_rx_pkg::packer_state_t exp,
                              input dma_rx_pkg::packer_state_t act);
      if (act !== exp) begin
         state_errs++;
         $display("Mismatch %s: expected %0d, actual %0d", name, exp, act);
      end
   endtask

   // Packing and statistics rules applied to one accepted ingress beat
   task automatic model_beat(input dma_rx_pkg::in_data_t d, input dma_rx_pkg::in_strb_t s,
                             input dma_rx_pkg::user_t u, input logic l);
      if (!mdl_open) mdl_user = u;   // First beat names the packet
      mdl_data[mdl_lane*64 +: 64] = d;
      mdl_strb[mdl_lane*8 +: 8]   = s;
      mdl_lane++;
      if (mdl_lane == 4 || l) begin
         exp_q.push_back({mdl_data, mdl_strb, mdl_user, l});
         mdl_data = '0;
         mdl_strb = '0;
         mdl_lane = 0;
      end
      mdl_open = !l;
      if (l) mdl_cnt[dma_rx_pkg::REG_PKT_IN]++;
      if (l || s == 8'hff) mdl_cnt[dma_rx_pkg::REG_WORD_IN]++;
      if (d == '0) mdl_cnt[dma_rx_pkg::REG_ERR_IN]++;
      mdl_cnt[dma_rx_pkg::REG_EXTRA_IN] = l ? '0 : mdl_cnt[dma_rx_pkg::REG_EXTRA_IN] + 1;
   endtask

   // Handshakes seen mid-cycle complete at the next rising edge
   task automatic observe();
      dma_rx_pkg::out_data_t ed;
      dma_rx_pkg::out_strb_t es;
      dma_rx_pkg::user_t     eu;
      logic                  el;
      if (m_axis_tvalid && m_axis_tready) begin
         if (exp_q.size() == 0) begin
            $display("Egress word in %s with no expected word left", test_name);
            other_errs++;
         end else begin
            {ed, es, eu, el} = exp_q.pop_front();
            check_word(test_name, ed, es, eu, el, m_axis_tdata, m_axis_tstrb, m_axis_tuser,
                       m_axis_tlast);
            mdl_cnt[dma_rx_pkg::REG_WORD_OUT]++;
            if (el) mdl_cnt[dma_rx_pkg::REG_PKT_OUT]++;
         end
      end
      if (s_axis_tvalid && s_axis_tready) begin
         model_beat(s_axis_tdata, s_axis_tstrb, s_axis_tuser, s_axis_tlast);
         beat_pending = 1'b0;
      end
   endtask

   task automatic cycle();
      logic [63:0] r;
      @(posedge M_AXIS_ACLK);
      take_bits(2, r);
      m_axis_tready <= !bp_en || r[1:0] != 2'd0;
      s_axis_tvalid <= beat_pending;
      s_axis_tdata  <= beat_data;
      s_axis_tstrb  <= beat_strb;
      s_axis_tuser  <= beat_user;
      s_axis_tlast  <= beat_last;
      wb_cyc        <= req_on;
      wb_stb        <= req_on;
      wb_we         <= req_we;
      wb_adr        <= req_adr;
      @(negedge M_AXIS_ACLK);
      observe();
   endtask

   task automatic send_packet(input int len, input logic close, input logic full);
      logic [63:0] r;
      int          n;
      for (int b = 0; b < len; b++) begin
         take_bits(2, r);
         if (bp_en && r[1:0] == 2'd0) cycle();   // Idle gap
         take_bits(64, r);
         beat_data = r;
         take_bits(13, r);
         if (!full && r[12:10] == 3'd0) beat_data = '0;   // Injected all-zero beat
         beat_strb = (full || r[9:8] != 2'd0) ? 8'hff : r[7:0];
         take_bits(64, r);
         beat_user[63:0] = r;
         take_bits(64, r);
         beat_user[127:64] = r;
         beat_last    = close && (b == len - 1);
         beat_pending = 1'b1;
         n = 0;
         while (beat_pending && n < 100) begin
            cycle();
            n++;
         end
         if (beat_pending) begin
            $display("Timeout: ingress beat %0d never accepted in %s", b, test_name);
            other_errs++;
            beat_pending = 1'b0;
         end
      end
   endtask

   task automatic drain();
      int n;
      n = 0;
      while ((exp_q.size() != 0 || m_axis_tvalid) && n < 300) begin
         cycle();
         n++;
      end
      if (exp_q.size() != 0 || m_axis_tvalid) begin
         $display("Timeout: egress words still pending at the end of %s", test_name);
         other_errs++;
      end
   endtask

   task automatic wb_access(input logic we, input dma_rx_pkg::reg_index_t idx,
                            output dma_rx_pkg::wb_dat_t rd);
      int n;
      req_on  = 1'b1;
      req_we  = we;
      req_adr = {idx, 2'b00};
      cycle();
      n = 0;
      while (!wb_ack && n < 16) begin
         cycle();
         n++;
      end
      rd = wb_dat_r;
      if (!wb_ack) begin
         $display("Timeout: no Wishbone acknowledge for register %0d in %s", idx, test_name);
         other_errs++;
      end
      req_on = 1'b0;
      cycle();
   endtask

   task automatic check_registers();
      dma_rx_pkg::wb_dat_t rd;
      for (int i = 0; i < 6; i++) begin
         wb_access(1'b0, dma_rx_pkg::reg_index_t'(i), rd);
         check_count($sformatf("%s reg %0d", test_name, i), mdl_cnt[i], rd);
      end
   endtask

   task automatic check_state_reg(input dma_rx_pkg::packer_state_t exp);
      dma_rx_pkg::wb_dat_t rd;
      wb_access(1'b0, dma_rx_pkg::REG_PACKER_STATE, rd);
      check_state({test_name, " state"}, exp, dma_rx_pkg::packer_state_t'(rd[1:0]));
   endtask

   task automatic random_traffic(input int npkts);
      logic [63:0] r;
      for (int p = 0; p < npkts; p++) begin
         take_bits(4, r);
         send_packet(int'(r[3:0]) % 11 + 1, 1'b1, 1'b0);   // 1 to 11 beats
      end
   endtask

   initial begin
      dma_rx_pkg::wb_dat_t rd;
      reset_n       <= 1'b0;
      s_axis_tdata  <= '0;
      s_axis_tstrb  <= '0;
      s_axis_tuser  <= '0;
      s_axis_tlast  <= 1'b0;
      s_axis_tvalid <= 1'b0;
      m_axis_tready <= 1'b0;
      wb_cyc        <= 1'b0;
      wb_stb        <= 1'b0;
      wb_we         <= 1'b0;
      wb_adr        <= '0;
      wb_dat_w      <= 32'hffff_ffff;
      {beat_data, beat_strb, beat_user, beat_last, beat_pending} = '0;
      {req_on, req_we, req_adr, bp_en} = '0;
      {mdl_data, mdl_strb, mdl_user, mdl_open} = '0;
      mdl_lane = 0;
      foreach (mdl_cnt[i]) mdl_cnt[i] = '0;
      {word_errs, count_errs, state_errs, other_errs} = '0;
      repeat (5) @(posedge M_AXIS_ACLK);
      reset_n <= 1'b1;

      test_name = "reset";
      cycle();
      if (m_axis_tvalid !== 1'b0 || s_axis_tready !== 1'b1) begin
         $display("Mismatch %s: expected tvalid 0 tready 1, actual tvalid %b tready %b",
                  test_name, m_axis_tvalid, s_axis_tready);
         other_errs++;
      end
      check_registers();
      wb_access(1'b0, dma_rx_pkg::REG_CLEAR, rd);
      check_count("reset reg 7", '0, rd);
      check_state_reg(dma_rx_pkg::PK_IDLE);

      test_name = "aligned";
      send_packet(4, 1'b1, 1'b1);
      send_packet(8, 1'b1, 1'b1);
      send_packet(12, 1'b1, 1'b1);
      drain();

      test_name = "random";
      bp_en = 1'b1;
      random_traffic(40);
      send_packet(3, 1'b0, 1'b0);   // Packet left open
      drain();
      check_registers();
      check_state_reg(dma_rx_pkg::PK_FILL);

      test_name = "close";
      send_packet(2, 1'b1, 1'b0);
      drain();
      check_registers();
      check_state_reg(dma_rx_pkg::PK_IDLE);

      test_name = "clear";
      wb_access(1'b1, dma_rx_pkg::REG_CLEAR, rd);
      foreach (mdl_cnt[i]) mdl_cnt[i] = '0;
      check_registers();
      random_traffic(15);
      drain();
      check_registers();
      check_state_reg(dma_rx_pkg::PK_IDLE);

      $display("Errors: word %0d, count %0d, state %0d, other %0d",
               word_errs, count_errs, state_errs, other_errs);
      if (word_errs + count_errs + state_errs + other_errs == 0) begin
         $display("Simulation passed");
      end else begin
         $display("Simulation failed");
      end
      $finish;
   end

endmodule

/* run_sim.sh */
#!/bin/sh
# Build and run the dma_rx_path testbench with Verilator
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --top-module dma_rx_path_tb \
   -f dma_rx_path.f -o dma_rx_path_sim
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

./obj_dir/dma_rx_path_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
   echo "Simulation binary returned status $status"
   exit 1
fi

if grep -q "Simulation failed" "$LOG"; then
   exit 1
fi
exit 0
